//--- filelist.f
fx_format_pkg.sv
alu_isa_pkg.sv
fx_arith_unit.sv
bit_manip_unit.sv
alu_ctrl.sv
alu_top.sv
tb_alu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_alu
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_alu.sv
`timescale 1ns/1ps

module tb_alu;

    import fx_format_pkg::*;
    import alu_isa_pkg::*;

    localparam int TIMEOUT_CYC = 10;
    localparam int N_RANDOM    = 230;

    localparam fx_word_t EXTREMES [6] = '{FX_MAX, FX_MIN, 16'sh0000, 16'sh0001,
                                          16'shffff, 16'sh0400};

    logic       i_clk;
    logic       i_rst_n;
    fx_word_t   i_data_a;
    fx_word_t   i_data_b;
    logic [3:0] i_inst;
    logic       o_busy;
    logic       o_valid;
    fx_word_t   o_data;

    fx_word_t   exp_data;                            // compared while o_valid is high.
    fx_word_t   last_res;                            // accumulator seen by the next mac.
    int         seed;
    int         n_ops;

    alu_top #(
        .FRAC_W    (FRAC_W_DEFAULT),
        .MAX_STEPS (LFSR_MAX_STEPS)
    ) alu_top_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_data_a (i_data_a),
        .i_data_b (i_data_b),
        .i_inst   (i_inst),
        .o_busy   (o_busy),
        .o_valid  (o_valid),
        .o_data   (o_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // ========================================================================
    // expected results
    // ========================================================================
    function automatic fx_word_t clamp_word(input longint v);
        if (v > longint'(FX_MAX)) begin
            return FX_MAX;
        end
        else if (v < longint'(FX_MIN)) begin
            return FX_MIN;
        end
        return fx_word_t'(v);
    endfunction

    function automatic fx_word_t sat_add_sub(input fx_word_t a, input fx_word_t b,
                                             input logic sub);
        if (sub) begin
            return clamp_word(longint'(a) - longint'(b));
        end
        return clamp_word(longint'(a) + longint'(b));
    endfunction

    function automatic fx_word_t round_mul(input fx_word_t a, input fx_word_t b,
                                           input fx_word_t acc, input logic mac);
        longint exact;
        exact = longint'(a) * longint'(b);           // q12.20.
        if (mac) begin
            exact = exact + longint'(acc) * (longint'(1) << FRAC_W_DEFAULT);
        end
        // half an lsb before the floor gives round half up.
        return clamp_word((exact + (longint'(1) << (FRAC_W_DEFAULT - 1))) >>> FRAC_W_DEFAULT);
    endfunction

    function automatic int lead_zeros(input fx_word_t a);
        int n;
        n = 0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (a[i]) begin
                break;
            end
            n++;
        end
        return n;
    endfunction

    function automatic fx_word_t rotate_invert(input fx_word_t a, input fx_word_t b);
        int       n;
        fx_word_t r;
        n = $countones(a);
        for (int i = 0; i < DATA_W; i++) begin
            if (i >= n) begin
                r[i] = b[i - n];
            end
            else begin
                r[i] = ~b[DATA_W - n + i];           // top bits return inverted.
            end
        end
        return r;
    endfunction

    function automatic fx_word_t lfsr_advance(input fx_word_t a, input fx_word_t b);
        int       steps;
        fx_word_t v;
        logic     fb;
        steps = int'(b);
        if (steps < 0 || steps > LFSR_MAX_STEPS) begin
            return '0;
        end
        v = a;
        for (int k = 0; k < steps; k++) begin
            fb = v[15] ^ v[13] ^ v[12] ^ v[10];
            v  = {v[14:0], fb};
        end
        return v;
    endfunction

    function automatic fx_word_t expected_result(input logic [3:0] inst, input fx_word_t a,
                                                 input fx_word_t b, input fx_word_t acc);
        case (inst)
            OP_ADD_FX: return sat_add_sub(a, b, 1'b0);
            OP_SUB_FX: return sat_add_sub(a, b, 1'b1);
            OP_MUL_FX: return round_mul(a, b, acc, 1'b0);
            OP_MAC:    return round_mul(a, b, acc, 1'b1);
            OP_CLZ:    return fx_word_t'(lead_zeros(a));
            OP_LRCW:   return rotate_invert(a, b);
            OP_LFSR:   return lfsr_advance(a, b);
            default:   return '0;
        endcase
    endfunction

    // ========================================================================
    // handshake
    // ========================================================================
    task automatic wait_idle();
        int cyc;
        cyc = 0;
        @(negedge i_clk);
        while (o_busy !== 1'b0) begin
            if (cyc == TIMEOUT_CYC) begin
                $display("o_busy did not fall within %0d cycles", TIMEOUT_CYC);
                $display("tests failed");
                $fatal(1, "wait for o_busy low expired");
            end
            else begin
                cyc++;
                @(negedge i_clk);
            end
        end
    endtask

    task automatic wait_result();
        int cyc;
        cyc = 0;
        @(negedge i_clk);
        while (o_valid !== 1'b1) begin
            if (cyc == TIMEOUT_CYC) begin
                $display("o_valid did not rise within %0d cycles", TIMEOUT_CYC);
                $display("tests failed");
                $fatal(1, "wait for o_valid high expired");
            end
            else begin
                cyc++;
                @(negedge i_clk);
            end
        end
    endtask

    // drive on the edge where o_busy falls, so the next edge samples.
    task automatic apply_op(input fx_word_t a, input fx_word_t b, input logic [3:0] inst);
        @(posedge i_clk);
        i_data_a <= a;
        i_data_b <= b;
        i_inst   <= inst;
        wait_idle();
        exp_data = expected_result(inst, a, b, last_res);
        wait_result();
        last_res = exp_data;
        n_ops++;
    endtask

    // ========================================================================
    // checks
    // ========================================================================
    a_data_check: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_valid |-> (o_data == exp_data)
    ) else begin
        $display("Error o_data expected 0x%h got 0x%h", exp_data, o_data);
        $display("tests failed");
        $fatal(1, "o_data mismatch");
    end

    a_valid_after_capture: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) ($past(o_busy, 2) == 1'b0) |-> o_valid
    ) else begin
        $display("o_valid did not rise two edges after the sampling edge");
        $display("tests failed");
        $fatal(1, "handshake timing");
    end

    a_valid_needs_capture: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_valid |-> ($past(o_busy, 2) == 1'b0)
    ) else begin
        $display("o_valid rose without a sampling edge two edges before");
        $display("tests failed");
        $fatal(1, "handshake timing");
    end

    a_valid_then_idle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_valid |=> (!o_valid && !o_busy)
    ) else begin
        $display("o_valid and o_busy did not both fall after the result cycle");
        $display("tests failed");
        $fatal(1, "handshake timing");
    end

    a_idle_one_cycle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !o_busy |=> o_busy
    ) else begin
        $display("o_busy stayed low for more than one cycle");
        $display("tests failed");
        $fatal(1, "handshake timing");
    end

    // ========================================================================
    // stimulus
    // ========================================================================
    initial begin
        i_rst_n  = 1'b0;
        i_data_a = '0;
        i_data_b = '0;
        i_inst   = '0;
        exp_data = '0;
        last_res = '0;                               // o_data is zero out of reset.
        seed     = 37;
        n_ops    = 0;

        repeat (7) @(posedge i_clk);
        @(negedge i_clk);
        assert (o_busy === 1'b1 && o_valid === 1'b0) else begin
            $display("o_busy not high or o_valid not low during reset");
            $display("tests failed");
            $fatal(1, "reset state");
        end
        @(posedge i_clk);
        i_rst_n <= 1'b1;

        // every pair of extremes through add, sub and mul.
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) begin
                apply_op(EXTREMES[i], EXTREMES[j], OP_ADD_FX);
                apply_op(EXTREMES[i], EXTREMES[j], OP_SUB_FX);
                apply_op(EXTREMES[i], EXTREMES[j], OP_MUL_FX);
            end
        end

        apply_op(16'sh0001, 16'sh0200, OP_MUL_FX);   // exact half lsb.
        apply_op(16'shffff, 16'sh0200, OP_MUL_FX);

        // mac chains up to positive saturation, then downward.
        apply_op(16'sh0400, 16'sh0c00, OP_MUL_FX);
        for (int k = 0; k < 12; k++) begin
            apply_op(16'sh0400, 16'sh0c00, OP_MAC);
        end
        for (int k = 0; k < 6; k++) begin
            apply_op(16'shfe00, 16'sh1a00, OP_MAC);
        end

        apply_op(16'sh0000, fx_word_t'($random(seed)), OP_CLZ);
        for (int i = 0; i < DATA_W; i++) begin
            apply_op(fx_word_t'(32'd1 << i), fx_word_t'($random(seed)), OP_CLZ);
        end

        for (int n = 0; n <= DATA_W; n++) begin
            apply_op(fx_word_t'((32'd1 << n) - 1), fx_word_t'($random(seed)), OP_LRCW);
        end

        for (int s = 0; s <= LFSR_MAX_STEPS + 1; s++) begin
            apply_op(16'shace1, fx_word_t'(s), OP_LFSR);
        end
        apply_op(16'shace1, 16'sh8000, OP_LFSR);
        apply_op(16'shace1, 16'sh0100, OP_LFSR);

        apply_op(fx_word_t'($random(seed)), fx_word_t'($random(seed)), 4'd4);
        for (int c = 8; c < 16; c++) begin
            apply_op(fx_word_t'($random(seed)), fx_word_t'($random(seed)), 4'(c));
        end

        for (int k = 0; k < N_RANDOM; k++) begin
            logic [3:0] op;
            fx_word_t   a;
            fx_word_t   b;
            op = 4'($random(seed));
            a  = fx_word_t'($random(seed));
            b  = fx_word_t'($random(seed));
            if (op == OP_LFSR) begin
                b = fx_word_t'($random(seed) & 15);  // step counts around the limit.
            end
            apply_op(a, b, op);
        end

        $display("%0d operations checked", n_ops);
        $display("all tests passed");
        $finish;
    end

endmodule

//--- alu_top.sv
`timescale 1ns/1ps

module alu_top #(
    parameter int FRAC_W    = fx_format_pkg::FRAC_W_DEFAULT,
    parameter int MAX_STEPS = alu_isa_pkg::LFSR_MAX_STEPS
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  fx_format_pkg::fx_word_t i_data_a,
    input  fx_format_pkg::fx_word_t i_data_b,
    input  logic [3:0]              i_inst,
    output logic                    o_busy,
    output logic                    o_valid,
    output fx_format_pkg::fx_word_t o_data
);

    import fx_format_pkg::*;
    import alu_isa_pkg::*;

    inst_t    inst_in;
    inst_t    op;
    fx_word_t op_a;
    fx_word_t op_b;
    fx_word_t arith_res;
    fx_word_t bit_res;

    assign inst_in = inst_t'(i_inst);                // all 16 codes pass through.

    alu_ctrl ctrl_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_data_a    (i_data_a),
        .i_data_b    (i_data_b),
        .i_inst      (inst_in),
        .i_arith_res (arith_res),
        .i_bit_res   (bit_res),
        .o_op_a      (op_a),
        .o_op_b      (op_b),
        .o_op        (op),
        .o_busy      (o_busy),
        .o_valid     (o_valid),
        .o_data      (o_data)
    );

    fx_arith_unit #(.FRAC_W(FRAC_W)) arith_i (
        .i_op   (op),
        .i_op_a (op_a),
        .i_op_b (op_b),
        .i_acc  (o_data),                            // previous result for mac.
        .o_res  (arith_res)
    );

    bit_manip_unit #(.MAX_STEPS(MAX_STEPS)) bit_i (
        .i_op   (op),
        .i_op_a (op_a),
        .i_op_b (op_b),
        .o_res  (bit_res)
    );

endmodule

//--- alu_ctrl.sv
`timescale 1ns/1ps

module alu_ctrl (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  fx_format_pkg::fx_word_t i_data_a,
    input  fx_format_pkg::fx_word_t i_data_b,
    input  alu_isa_pkg::inst_t      i_inst,
    input  fx_format_pkg::fx_word_t i_arith_res,
    input  fx_format_pkg::fx_word_t i_bit_res,
    output fx_format_pkg::fx_word_t o_op_a,
    output fx_format_pkg::fx_word_t o_op_b,
    output alu_isa_pkg::inst_t      o_op,
    output logic                    o_busy,
    output logic                    o_valid,
    output fx_format_pkg::fx_word_t o_data
);

    import fx_format_pkg::*;
    import alu_isa_pkg::*;

    typedef enum logic [1:0] {
        WAIT,
        CAPTURE,
        EXECUTE,
        RESULT
    } state_t;

    state_t   state;
    state_t   state_nxt;
    logic     busy_q;
    logic     valid_q;
    fx_word_t data_q;
    fx_word_t op_a_q;
    fx_word_t op_b_q;
    inst_t    op_q;
    op_unit_t unit_sel;
    logic     op_used;
    fx_word_t res_sel;

    // ========================================================================
    // handshake FSM
    // ========================================================================
    always_comb begin
        case (state)
            WAIT:    state_nxt = CAPTURE;            // only left once after reset.
            CAPTURE: state_nxt = EXECUTE;
            EXECUTE: state_nxt = RESULT;
            default: state_nxt = CAPTURE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= WAIT;
            busy_q  <= 1'b1;
            valid_q <= 1'b0;
            data_q  <= '0;
        end
        else begin
            state   <= state_nxt;
            busy_q  <= (state_nxt != CAPTURE);
            valid_q <= (state_nxt == RESULT);
            if (state == EXECUTE) begin
                data_q <= res_sel;                   // held until the next result.
            end
        end
    end

    // operands are sampled at the edge that ends a not-busy cycle.
    always_ff @(posedge i_clk) begin
        if (!busy_q) begin
            op_a_q <= i_data_a;
            op_b_q <= i_data_b;
            op_q   <= i_inst;
        end
    end

    // ========================================================================
    // result select
    // ========================================================================
    always_comb begin
        unit_sel = UNIT_ARITH;
        op_used  = 1'b1;
        case (op_q)
            OP_ADD_FX, OP_SUB_FX, OP_MUL_FX, OP_MAC: begin
                unit_sel = UNIT_ARITH;
            end
            OP_CLZ, OP_LRCW, OP_LFSR: begin
                unit_sel = UNIT_BIT;
            end
            default: begin
                op_used = 1'b0;                      // unused code.
            end
        endcase

        if (!op_used) begin
            res_sel = '0;
        end
        else if (unit_sel == UNIT_BIT) begin
            res_sel = i_bit_res;
        end
        else begin
            res_sel = i_arith_res;
        end
    end

    assign o_op_a  = op_a_q;
    assign o_op_b  = op_b_q;
    assign o_op    = op_q;
    assign o_busy  = busy_q;
    assign o_valid = valid_q;
    assign o_data  = data_q;

    a_valid_in_busy: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_valid |-> o_busy
    ) else $error("alu_ctrl o_valid high while o_busy low");

    a_valid_single: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_valid |=> !o_valid
    ) else $error("alu_ctrl o_valid high for two cycles");

endmodule

//--- bit_manip_unit.sv
`timescale 1ns/1ps

module bit_manip_unit #(
    parameter int MAX_STEPS = alu_isa_pkg::LFSR_MAX_STEPS
) (
    input  alu_isa_pkg::inst_t      i_op,
    input  fx_format_pkg::fx_word_t i_op_a,
    input  fx_format_pkg::fx_word_t i_op_b,
    output fx_format_pkg::fx_word_t o_res
);

    import fx_format_pkg::*;
    import alu_isa_pkg::*;

    cnt_t     clz;
    cnt_t     pop;
    fx_word_t lrcw;
    fx_word_t lfsr;
    fx_word_t lfsr_stage [0:MAX_STEPS];

    // one shift of the x^16 + x^14 + x^13 + x^11 + 1 fibonacci register.
    function automatic fx_word_t lfsr_step(input fx_word_t v);
        return {v[DATA_W-2:0], v[15] ^ v[13] ^ v[12] ^ v[10]};
    endfunction

    // ========================================================================
    // leading zeros and popcount
    // ========================================================================
    always_comb begin
        clz = cnt_t'(DATA_W);                        // all zero.
        for (int i = 0; i < DATA_W; i++) begin
            if (i_op_a[i]) begin
                clz = cnt_t'(DATA_W - 1 - i);        // highest set bit wins.
            end
        end
    end

    always_comb begin
        pop = '0;
        for (int i = 0; i < DATA_W; i++) begin
            pop = pop + cnt_t'(i_op_a[i]);
        end
    end

    // ========================================================================
    // rotate with inversion
    // ========================================================================
    // b moves left by popcount(a), the bits pushed out return inverted at
    // the bottom. n = 16 leaves ~b, n = 0 leaves b.
    always_comb begin
        lrcw = (i_op_b << pop) | (~i_op_b >> (DATA_W - pop));
    end

    // ========================================================================
    // multi-step lfsr
    // ========================================================================
    always_comb begin
        lfsr_stage[0] = i_op_a;
        for (int k = 1; k <= MAX_STEPS; k++) begin
            lfsr_stage[k] = lfsr_step(lfsr_stage[k-1]);
        end

        lfsr = '0;                                   // negative or too many steps.
        for (int k = 0; k <= MAX_STEPS; k++) begin
            if (i_op_b == fx_word_t'(k)) begin
                lfsr = lfsr_stage[k];
            end
        end
    end

    always_comb begin
        case (i_op)
            OP_CLZ: begin
                o_res = fx_word_t'(clz);
            end
            OP_LRCW: begin
                o_res = lrcw;
            end
            OP_LFSR: begin
                o_res = lfsr;
            end
            default: begin
                o_res = '0;
            end
        endcase
    end

endmodule

//--- fx_arith_unit.sv
`timescale 1ns/1ps

module fx_arith_unit #(
    parameter int FRAC_W = fx_format_pkg::FRAC_W_DEFAULT
) (
    input  alu_isa_pkg::inst_t      i_op,
    input  fx_format_pkg::fx_word_t i_op_a,
    input  fx_format_pkg::fx_word_t i_op_b,
    input  fx_format_pkg::fx_word_t i_acc,
    output fx_format_pkg::fx_word_t o_res
);

    import fx_format_pkg::*;
    import alu_isa_pkg::*;

    localparam int RND_W = $bits(fx_round_t);

    fx_wide_t  sum;
    fx_prod_t  prod;
    fx_prod_t  acc_shl;
    fx_prod_t  prod_sel;
    fx_prod_t  prod_shr;
    fx_round_t prod_rnd;
    fx_round_t pre_sat;

    // clamp a q12.10 value to the word range.
    function automatic fx_word_t sat_word(input fx_round_t v);
        if (v > fx_round_t'(FX_MAX)) begin
            return FX_MAX;
        end
        else if (v < fx_round_t'(FX_MIN)) begin
            return FX_MIN;
        end
        return v[DATA_W-1:0];
    endfunction

    // ========================================================================
    // add and subtract
    // ========================================================================
    always_comb begin
        if (i_op == OP_SUB_FX) begin
            sum = fx_wide_t'(i_op_a) - fx_wide_t'(i_op_b);
        end
        else begin
            sum = fx_wide_t'(i_op_a) + fx_wide_t'(i_op_b);
        end
    end

    // ========================================================================
    // multiply and multiply-accumulate
    // ========================================================================
    always_comb begin
        prod    = fx_prod_t'(i_op_a) * fx_prod_t'(i_op_b);
        acc_shl = fx_prod_t'(i_acc) <<< FRAC_W;        // accumulator moved to q12.20.

        if (i_op == OP_MAC) begin
            prod_sel = prod + acc_shl;
        end
        else begin
            prod_sel = prod;
        end

        // round half up on the first dropped bit.
        prod_shr = prod_sel >>> FRAC_W;
        prod_rnd = fx_round_t'(prod_shr[RND_W-1:0]) + fx_round_t'(prod_sel[FRAC_W-1]);
    end

    // ========================================================================
    // result select and saturation
    // ========================================================================
    always_comb begin
        case (i_op)
            OP_ADD_FX,
            OP_SUB_FX: begin
                pre_sat = fx_round_t'(sum);
            end
            OP_MUL_FX,
            OP_MAC: begin
                pre_sat = prod_rnd;
            end
            default: begin
                pre_sat = '0;
            end
        endcase

        o_res = sat_word(pre_sat);

        // a clamped or truncated word keeps the sign of the exact value.
        if (!$isunknown(pre_sat)) begin
            assert (o_res[DATA_W-1] == pre_sat[RND_W-1])
                else $error("fx_arith_unit result sign differs from exact value");
        end
    end

endmodule

//--- alu_isa_pkg.sv
package alu_isa_pkg;

    // ========================================================================
    // instruction set
    // ========================================================================
    // codes 4 and 8 to 15 are accepted and return zero.
    typedef enum logic [3:0] {
        OP_ADD_FX = 4'd0,
        OP_SUB_FX = 4'd1,
        OP_MUL_FX = 4'd2,
        OP_MAC    = 4'd3,
        OP_CLZ    = 4'd5,
        OP_LRCW   = 4'd6,
        OP_LFSR   = 4'd7
    } inst_t;

    // execution unit that serves an opcode.
    typedef enum logic {
        UNIT_ARITH = 1'b0,
        UNIT_BIT   = 1'b1
    } op_unit_t;

    localparam int LFSR_MAX_STEPS = 8;               // larger step counts give zero.

endpackage

//--- fx_format_pkg.sv
package fx_format_pkg;

    // ========================================================================
    // fixed-point word formats
    // ========================================================================
    localparam int DATA_W         = 16;
    localparam int FRAC_W_DEFAULT = 10;                // q6.10 operands.

    localparam int WIDE_W  = DATA_W + 1;
    localparam int PROD_W  = 2 * DATA_W;
    localparam int ROUND_W = 22;

    // operand or result word.
    typedef logic signed [DATA_W-1:0]  fx_word_t;

    // sum or difference, one guard bit above the word.
    typedef logic signed [WIDE_W-1:0]  fx_wide_t;

    // full product or accumulator, q12.20.
    typedef logic signed [PROD_W-1:0]  fx_prod_t;

    // product after dropping the low fraction, q12.10.
    typedef logic signed [ROUND_W-1:0] fx_round_t;

    // bit count, 0 to 16.
    typedef logic [4:0] cnt_t;

    // ========================================================================
    // saturation limits
    // ========================================================================
    localparam fx_word_t FX_MAX = fx_word_t'({1'b0, {(DATA_W-1){1'b1}}});
    localparam fx_word_t FX_MIN = fx_word_t'({1'b1, {(DATA_W-1){1'b0}}});

endpackage
